//--- Makefile
# Verilator build and run of the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= conv_tb
FILELIST  ?= conv.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= SIMULATION PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass message not found in $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/conv_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface conv_ctrl_if ();

    logic clear;    // Frame start, empties window and counter
    logic shift;    // Window moves one place
    logic flush;    // Shift in zero instead of the sample
    logic compute;  // Dot product on the window after this shift
    logic last;     // Final computation of the frame

    // Sequencer side
    modport seq (
        output clear,
        output shift,
        output flush,
        output compute,
        output last
    );

    // Counter, window and MAC side
    modport datapath (
        input clear,
        input shift,
        input flush,
        input compute,
        input last
    );

endinterface

`default_nettype wire

//--- common/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // Frame sequencer states
    typedef enum logic [1:0] {
        ST_IDLE            = 2'b00,
        ST_COMPUTE         = 2'b01,
        ST_WAIT_SAMPLE     = 2'b10,
        ST_WAIT_COMPLETION = 2'b11
    } conv_state_t;

    // Default sizes for the engine
    localparam int DEFAULT_DATA_WIDTH = 8;
    localparam int DEFAULT_COEF_WIDTH = 8;
    localparam int DEFAULT_N_TAPS     = 8;
    localparam int DEFAULT_N_SAMPLES  = 8;

    // Full precision width of an n_taps dot product
    function automatic int acc_width(
        input int data_width,
        input int coef_width,
        input int n_taps
    );
        return data_width + coef_width + $clog2(n_taps);
    endfunction

endpackage

`default_nettype wire

//--- conv.f
common/conv_pkg.sv
common/conv_ctrl_if.sv
conv_engine/conv_sequencer.sv
conv_engine/conv_index_counter.sv
conv_engine/sample_window.sv
conv_engine/kernel_bank.sv
conv_engine/mac_tree.sv
source/conv_top.sv
testbench/clock_gen.sv
testbench/conv_tb.sv

//--- conv_engine/conv_index_counter.sv
`timescale 1ns/1ps
`default_nettype none

module conv_index_counter #(
    parameter int N_SAMPLES = conv_pkg::DEFAULT_N_SAMPLES,
    parameter int N_TAPS    = conv_pkg::DEFAULT_N_TAPS
) (
    input  logic          clk,
    input  logic          reset,
    conv_ctrl_if.datapath ctrl,
    output logic          samples_done,
    output logic          flush_done
);

    // Holds every position up to the one past the last flush
    localparam int CNT_WIDTH = $clog2(N_SAMPLES + N_TAPS);

    localparam logic [CNT_WIDTH-1:0] LAST_SAMPLE = CNT_WIDTH'(N_SAMPLES - 1);
    localparam logic [CNT_WIDTH-1:0] LAST_FLUSH  = CNT_WIDTH'(N_SAMPLES + N_TAPS - 2);

    logic [CNT_WIDTH-1:0] count;

    // Number of shifts already done in this frame
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (ctrl.clear) begin
            count <= '0;
        end else if (ctrl.shift) begin
            count <= count + 1'b1;
        end
    end

    // Current shift carries the final sample
    assign samples_done = (count == LAST_SAMPLE);

    // Current shift is the final zero of the tail
    assign flush_done = (count == LAST_FLUSH);

endmodule

`default_nettype wire

//--- conv_engine/conv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  logic     sample_valid,
    input  logic     samples_done,
    input  logic     flush_done,
    output logic     busy,
    conv_ctrl_if.seq ctrl
);

    import conv_pkg::*;

    conv_state_t state;
    conv_state_t next_state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state   = state;
        ctrl.clear   = 1'b0;
        ctrl.shift   = 1'b0;
        ctrl.flush   = 1'b0;
        ctrl.compute = 1'b0;
        ctrl.last    = 1'b0;

        case (state)
            ST_IDLE: begin
                if (start) begin
                    ctrl.clear = 1'b1;  // Fresh history for the new frame
                    next_state = ST_COMPUTE;
                end
            end

            // Both states accept a sample, they differ only for waveforms
            ST_COMPUTE, ST_WAIT_SAMPLE: begin
                if (sample_valid) begin
                    ctrl.shift   = 1'b1;
                    ctrl.compute = 1'b1;
                    if (samples_done && flush_done) begin
                        // Single tap kernel has no tail to drain
                        ctrl.last  = 1'b1;
                        next_state = ST_IDLE;
                    end else if (samples_done) begin
                        next_state = ST_WAIT_COMPLETION;
                    end else begin
                        next_state = ST_COMPUTE;
                    end
                end else begin
                    next_state = ST_WAIT_SAMPLE;
                end
            end

            ST_WAIT_COMPLETION: begin
                // Tail drain, one zero per cycle
                ctrl.shift   = 1'b1;
                ctrl.flush   = 1'b1;
                ctrl.compute = 1'b1;
                if (flush_done) begin
                    ctrl.last  = 1'b1;
                    next_state = ST_IDLE;
                end
            end

            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    assign busy = (state != ST_IDLE);

endmodule

`default_nettype wire

//--- conv_engine/kernel_bank.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_bank #(
    parameter int COEF_WIDTH = conv_pkg::DEFAULT_COEF_WIDTH,
    parameter int N_TAPS     = conv_pkg::DEFAULT_N_TAPS
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         coef_wr,
    input  logic [$clog2(N_TAPS):0]      coef_addr,
    input  logic [COEF_WIDTH-1:0]        coef_data,
    input  logic                         busy,
    output logic [N_TAPS*COEF_WIDTH-1:0] kernel
);

    localparam int ADDR_WIDTH = $clog2(N_TAPS) + 1;

    // coef_reg[k] weights the sample that is k places old
    logic [COEF_WIDTH-1:0] coef_reg [N_TAPS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < N_TAPS; k++) begin
                coef_reg[k] <= '0;
            end
        end else if (coef_wr && !busy) begin
            // Addresses at N_TAPS or above match no register
            for (int k = 0; k < N_TAPS; k++) begin
                if (coef_addr == ADDR_WIDTH'(k)) begin
                    coef_reg[k] <= coef_data;
                end
            end
        end
    end

    for (genvar k = 0; k < N_TAPS; k++) begin : g_flat
        assign kernel[k*COEF_WIDTH +: COEF_WIDTH] = coef_reg[k];
    end

endmodule

`default_nettype wire

//--- conv_engine/mac_tree.sv
`timescale 1ns/1ps
`default_nettype none

module mac_tree #(
    parameter int DATA_WIDTH = conv_pkg::DEFAULT_DATA_WIDTH,
    parameter int COEF_WIDTH = conv_pkg::DEFAULT_COEF_WIDTH,
    parameter int N_TAPS     = conv_pkg::DEFAULT_N_TAPS
) (
    input  logic                         clk,
    input  logic                         reset,
    conv_ctrl_if.datapath                ctrl,
    input  logic [N_TAPS*DATA_WIDTH-1:0] window,
    input  logic [N_TAPS*COEF_WIDTH-1:0] kernel,
    output logic signed [conv_pkg::acc_width(DATA_WIDTH, COEF_WIDTH, N_TAPS)-1:0] y,
    output logic                         y_valid,
    output logic                         y_last
);

    import conv_pkg::*;

    localparam int PROD_WIDTH = DATA_WIDTH + COEF_WIDTH;
    localparam int ACC_WIDTH  = acc_width(DATA_WIDTH, COEF_WIDTH, N_TAPS);

    logic signed [DATA_WIDTH-1:0] sample_tap [N_TAPS];
    logic signed [COEF_WIDTH-1:0] coef_tap   [N_TAPS];
    logic signed [PROD_WIDTH-1:0] prod       [N_TAPS];
    logic signed [ACC_WIDTH-1:0]  sum_next;
    logic                         compute_d;
    logic                         last_d;
    logic                         prod_valid;
    logic                         prod_last;

    for (genvar k = 0; k < N_TAPS; k++) begin : g_taps
        assign sample_tap[k] = window[k*DATA_WIDTH +: DATA_WIDTH];
        assign coef_tap[k]   = kernel[k*COEF_WIDTH +: COEF_WIDTH];
    end

    // Window takes the new sample on the same edge, so wait one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            compute_d <= 1'b0;
            last_d    <= 1'b0;
        end else begin
            compute_d <= ctrl.compute;
            last_d    <= ctrl.last;
        end
    end

    // Stage one, per-tap products
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
            for (int k = 0; k < N_TAPS; k++) begin
                prod[k] <= '0;
            end
        end else begin
            prod_valid <= compute_d;
            prod_last  <= compute_d && last_d;
            if (compute_d) begin
                for (int k = 0; k < N_TAPS; k++) begin
                    prod[k] <= PROD_WIDTH'(sample_tap[k]) * PROD_WIDTH'(coef_tap[k]);
                end
            end
        end
    end

    always_comb begin
        sum_next = '0;
        for (int k = 0; k < N_TAPS; k++) begin
            sum_next = sum_next + ACC_WIDTH'(prod[k]);  // Sign extended
        end
    end

    // Stage two, registered sum
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            y       <= '0;
            y_valid <= 1'b0;
            y_last  <= 1'b0;
        end else begin
            y_valid <= prod_valid;
            y_last  <= prod_last;
            if (prod_valid) begin
                y <= sum_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- conv_engine/sample_window.sv
`timescale 1ns/1ps
`default_nettype none

module sample_window #(
    parameter int DATA_WIDTH = conv_pkg::DEFAULT_DATA_WIDTH,
    parameter int N_TAPS     = conv_pkg::DEFAULT_N_TAPS
) (
    input  logic                         clk,
    input  logic                         reset,
    conv_ctrl_if.datapath                ctrl,
    input  logic [DATA_WIDTH-1:0]        sample_data,
    output logic [N_TAPS*DATA_WIDTH-1:0] window
);

    // taps[0] is the newest sample
    logic [DATA_WIDTH-1:0] taps [N_TAPS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < N_TAPS; k++) begin
                taps[k] <= '0;
            end
        end else if (ctrl.clear) begin
            for (int k = 0; k < N_TAPS; k++) begin
                taps[k] <= '0;
            end
        end else if (ctrl.shift) begin
            taps[0] <= ctrl.flush ? '0 : sample_data;  // Zeros drain the tail
            for (int k = 1; k < N_TAPS; k++) begin
                taps[k] <= taps[k-1];
            end
        end
    end

    // Tap k sits at slice k of the flat bus
    for (genvar k = 0; k < N_TAPS; k++) begin : g_flat
        assign window[k*DATA_WIDTH +: DATA_WIDTH] = taps[k];
    end

endmodule

`default_nettype wire

//--- source/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top #(
    parameter int DATA_WIDTH = conv_pkg::DEFAULT_DATA_WIDTH,
    parameter int COEF_WIDTH = conv_pkg::DEFAULT_COEF_WIDTH,
    parameter int N_TAPS     = conv_pkg::DEFAULT_N_TAPS,
    parameter int N_SAMPLES  = conv_pkg::DEFAULT_N_SAMPLES
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    coef_wr,
    input  logic [$clog2(N_TAPS):0] coef_addr,
    input  logic [COEF_WIDTH-1:0]   coef_data,
    input  logic                    sample_valid,
    input  logic [DATA_WIDTH-1:0]   sample_data,
    output logic                    busy,
    output logic signed [conv_pkg::acc_width(DATA_WIDTH, COEF_WIDTH, N_TAPS)-1:0] y,
    output logic                    y_valid,
    output logic                    y_last
);

    conv_ctrl_if ctrl ();

    logic                         samples_done;
    logic                         flush_done;
    logic [N_TAPS*DATA_WIDTH-1:0] window;
    logic [N_TAPS*COEF_WIDTH-1:0] kernel;

    conv_sequencer seq0 (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .sample_valid (sample_valid),
        .samples_done (samples_done),
        .flush_done   (flush_done),
        .busy         (busy),
        .ctrl         (ctrl.seq)
    );

    conv_index_counter #(
        .N_SAMPLES (N_SAMPLES),
        .N_TAPS    (N_TAPS)
    ) cnt0 (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl.datapath),
        .samples_done (samples_done),
        .flush_done   (flush_done)
    );

    sample_window #(
        .DATA_WIDTH (DATA_WIDTH),
        .N_TAPS     (N_TAPS)
    ) win0 (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl.datapath),
        .sample_data (sample_data),
        .window      (window)
    );

    // Writes are locked out while a frame runs
    kernel_bank #(
        .COEF_WIDTH (COEF_WIDTH),
        .N_TAPS     (N_TAPS)
    ) kbank0 (
        .clk       (clk),
        .reset     (reset),
        .coef_wr   (coef_wr),
        .coef_addr (coef_addr),
        .coef_data (coef_data),
        .busy      (busy),
        .kernel    (kernel)
    );

    mac_tree #(
        .DATA_WIDTH (DATA_WIDTH),
        .COEF_WIDTH (COEF_WIDTH),
        .N_TAPS     (N_TAPS)
    ) mac0 (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl.datapath),
        .window  (window),
        .kernel  (kernel),
        .y       (y),
        .y_valid (y_valid),
        .y_last  (y_last)
    );

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #1 reset = 1'b0;  // Released just after the edge, like the other inputs
    end

endmodule

`default_nettype wire

//--- testbench/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tb;

    localparam int DATA_WIDTH  = 8;
    localparam int COEF_WIDTH  = 8;
    localparam int N_TAPS      = 4;
    localparam int N_SAMPLES   = 6;
    localparam int ADDR_WIDTH  = $clog2(N_TAPS) + 1;
    localparam int ACC_WIDTH   = DATA_WIDTH + COEF_WIDTH + $clog2(N_TAPS);
    localparam int N_OUTPUTS   = N_SAMPLES + N_TAPS - 1;
    localparam int LATENCY     = 3;    // Sample strobe to y_valid
    localparam int DRIVE_DELAY = 1;
    localparam int WAIT_LIMIT  = 200;

    logic                         clk;
    logic                         reset;
    logic                         start;
    logic                         coef_wr;
    logic [ADDR_WIDTH-1:0]        coef_addr;
    logic [COEF_WIDTH-1:0]        coef_data;
    logic                         sample_valid;
    logic [DATA_WIDTH-1:0]        sample_data;
    logic                         busy;
    logic signed [ACC_WIDTH-1:0]  y;
    logic                         y_valid;
    logic                         y_last;

    logic signed [COEF_WIDTH-1:0] kernel_model [N_TAPS];
    logic signed [DATA_WIDTH-1:0] frame_model  [N_SAMPLES];

    // Expected results in output order
    logic [ACC_WIDTH-1:0] exp_y_q     [$];
    logic                 exp_last_q  [$];
    int                   exp_cycle_q [$];

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          error_count;

    clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (2)
    ) clk0 (
        .clk   (clk),
        .reset (reset)
    );

    conv_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .COEF_WIDTH (COEF_WIDTH),
        .N_TAPS     (N_TAPS),
        .N_SAMPLES  (N_SAMPLES)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .coef_wr      (coef_wr),
        .coef_addr    (coef_addr),
        .coef_data    (coef_data),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .busy         (busy),
        .y            (y),
        .y_valid      (y_valid),
        .y_last       (y_last)
    );

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Full convolution with zero samples outside the frame
    function automatic logic [ACC_WIDTH-1:0] reference_output(input int n);
        int sum;
        sum = 0;
        for (int k = 0; k < N_TAPS; k++) begin
            if (n - k >= 0 && n - k < N_SAMPLES) begin
                sum += int'(kernel_model[k]) * int'(frame_model[n - k]);
            end
        end
        return ACC_WIDTH'(sum);
    endfunction

    task automatic stop_run();
        error_count++;
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic expect_output(input int n, input int at_cycle);
        exp_y_q.push_back(reference_output(n));
        exp_last_q.push_back(n == N_OUTPUTS - 1);
        exp_cycle_q.push_back(at_cycle);
    endtask

    task automatic compare_output();
        logic [ACC_WIDTH-1:0] exp_y;
        logic                 exp_last;
        int                   exp_cycle;
        if (exp_y_q.size() == 0) begin
            $display("y_valid went high at cycle %0d with no result expected", cycle_count);
            stop_run();
        end else begin
            exp_y     = exp_y_q.pop_front();
            exp_last  = exp_last_q.pop_front();
            exp_cycle = exp_cycle_q.pop_front();
            check_value("y", 64'($unsigned(y)), 64'(exp_y));
            check_value("y_last", 64'(y_last), 64'(exp_last));
            check_value("y_valid cycle", 64'(cycle_count), 64'(exp_cycle));
        end
    endtask

    // Outputs sampled at the falling edge
    always @(negedge clk) begin
        if (!reset && y_valid) begin
            compare_output();
        end else if (!reset) begin
            check_value("y_last", 64'(y_last), 64'(0));
        end
    end

    // Step to the next cycle and drop all strobes
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        start        = 1'b0;
        coef_wr      = 1'b0;
        sample_valid = 1'b0;
    endtask

    task automatic write_coef(input int addr, input logic [COEF_WIDTH-1:0] data,
                              input bit honored);
        next_cycle();
        coef_wr   = 1'b1;
        coef_addr = ADDR_WIDTH'(addr);
        coef_data = data;
        if (honored && addr < N_TAPS) begin
            kernel_model[addr] = data;
        end
    endtask

    task automatic load_kernel();
        logic [31:0] r;
        for (int k = 0; k < N_TAPS; k++) begin
            random_bits(COEF_WIDTH, r);
            write_coef(k, r[COEF_WIDTH-1:0], 1'b1);
        end
        write_coef(N_TAPS, ~kernel_model[0], 1'b1);  // Out of range address
    endtask

    // Idle strobes that must not reach the output
    task automatic stray_strobes(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            next_cycle();
            check_value("busy", 64'(busy), 64'(0));
            check_value("y_valid", 64'(y_valid), 64'(0));
            random_bits(DATA_WIDTH, r);
            sample_valid = 1'b1;
            sample_data  = r[DATA_WIDTH-1:0];
        end
    endtask

    task automatic wait_busy_low();
        int n;
        n = 0;
        while (busy !== 1'b0) begin
            if (n >= WAIT_LIMIT) begin
                $display("timeout: busy stayed high for %0d cycles", WAIT_LIMIT);
                stop_run();
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_y_q.size() != 0) begin
            if (n >= WAIT_LIMIT) begin
                $display("timeout: %0d results never appeared on y_valid", exp_y_q.size());
                stop_run();
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    task automatic run_frame(input int gap_max, input bit start_now, input bit stray_tail,
                             input bit busy_write);
        logic [31:0] r;
        int          gap;
        int          last_cycle;
        int          addr;
        for (int i = 0; i < N_SAMPLES; i++) begin
            random_bits(DATA_WIDTH, r);
            frame_model[i] = r[DATA_WIDTH-1:0];
        end
        if (!start_now) begin
            next_cycle();
        end
        start = 1'b1;
        for (int i = 0; i < N_SAMPLES; i++) begin
            gap = 0;
            if (gap_max > 0) begin
                random_bits(4, r);
                gap = int'(r[3:0]) % (gap_max + 1);
            end
            repeat (gap) begin
                next_cycle();
            end
            next_cycle();
            check_value("busy", 64'(busy), 64'(1));
            sample_valid = 1'b1;
            sample_data  = frame_model[i];
            expect_output(i, cycle_count + LATENCY);
            if (busy_write && i == N_SAMPLES / 2) begin
                random_bits(ADDR_WIDTH - 1, r);
                addr      = int'(r[ADDR_WIDTH-2:0]);
                coef_wr   = 1'b1;  // Write attempt during the frame
                coef_addr = ADDR_WIDTH'(addr);
                coef_data = ~kernel_model[addr];
            end
        end
        last_cycle = cycle_count;
        // Tail zeros follow the last sample on consecutive cycles
        for (int j = N_SAMPLES; j < N_OUTPUTS; j++) begin
            expect_output(j, last_cycle + LATENCY + j - N_SAMPLES + 1);
        end
        if (stray_tail) begin
            for (int t = 1; t < N_TAPS; t++) begin
                next_cycle();
                random_bits(DATA_WIDTH, r);
                sample_valid = 1'b1;
                sample_data  = r[DATA_WIDTH-1:0];
            end
        end
        wait_busy_low();
    endtask

    initial begin
        int n;
        lfsr_state     = 32'h91e3;
        error_count    = 0;
        start          = 1'b0;
        coef_wr        = 1'b0;
        coef_addr      = '0;
        coef_data      = '0;
        sample_valid   = 1'b0;
        sample_data    = '0;
        for (int k = 0; k < N_TAPS; k++) begin
            kernel_model[k] = '0;
        end

        n = 0;
        while (reset !== 1'b0) begin
            if (n >= WAIT_LIMIT) begin
                $display("timeout: reset was never released");
                stop_run();
            end else begin
                @(posedge clk);
                n++;
            end
        end

        stray_strobes(6);              // Strobes before the first start
        load_kernel();
        run_frame(0, 1'b0, 1'b0, 1'b0);  // Back-to-back samples
        wait_drained();
        run_frame(3, 1'b0, 1'b0, 1'b0);  // Random gaps
        wait_drained();
        stray_strobes(3);
        run_frame(1, 1'b0, 1'b1, 1'b0);  // Extra strobes in the tail
        wait_drained();

        load_kernel();
        run_frame(2, 1'b0, 1'b0, 1'b1);  // Write attempt while busy
        run_frame(0, 1'b1, 1'b0, 1'b0);
        wait_drained();

        // Back-to-back frames with start right after busy falls
        for (int f = 0; f < 4; f++) begin
            run_frame(f, f > 0, 1'b0, 1'b0);
        end
        wait_drained();

        // No result may follow the last frame
        for (int i = 0; i < N_OUTPUTS; i++) begin
            next_cycle();
        end

        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
